/* mont_pkg.sv */
package mont_pkg;

    // Operand width N, the full-size design runs at 1024
    localparam int unsigned OP_W = 128;

    // Holds c + 3b + 3m with the carry on top
    localparam int unsigned ACC_W = OP_W + 4;

    // Bits per adder clock
    localparam int unsigned LIMB_W = 33;
    localparam int unsigned NUM_LIMBS = ACC_W / LIMB_W;

    // One radix-4 digit of a per loop step
    localparam int unsigned NUM_DIGITS = OP_W / 2;
    localparam int unsigned DIGIT_CNT_W = $clog2(NUM_DIGITS + 1);
    localparam logic [DIGIT_CNT_W-1:0] LAST_DIGIT = DIGIT_CNT_W'(NUM_DIGITS - 1);

    typedef logic [OP_W-1:0] op_t;
    typedef logic [ACC_W-1:0] acc_t;

    typedef enum logic [3:0] {
        CORE_IDLE,
        CORE_B3_ISSUE,
        CORE_B3_WAIT,
        CORE_M3_ISSUE,
        CORE_M3_WAIT,
        CORE_BMUL_ISSUE,
        CORE_BMUL_WAIT,
        CORE_MMUL_ISSUE,
        CORE_MMUL_WAIT,
        CORE_HANDOFF
    } core_state_t;

endpackage

/* adder_if.sv */
`timescale 1ns/1ps

// Request to a limb adder and its result
interface adder_if;

    logic           start;
    logic           subtract;
    mont_pkg::acc_t op_a;
    mont_pkg::acc_t op_b;
    // Top bit is the carry out, set on a subtract when nothing was borrowed
    mont_pkg::acc_t sum;
    logic           done;

    modport requester (
        output start, subtract, op_a, op_b,
        input  sum, done
    );

    modport adder (
        input  start, subtract, op_a, op_b,
        output sum, done
    );

endinterface

/* operand_if.sv */
`timescale 1ns/1ps

// Operand registers to core
interface operand_if;

    // Core side strobes and data
    logic                  load;
    logic                  shift_a;
    logic                  capture_b3;
    logic                  capture_m3;
    logic [1:0]            acc_low;
    mont_pkg::acc_t        triple;

    // Register side
    mont_pkg::op_t         b;
    mont_pkg::op_t         m;
    mont_pkg::acc_t        b_multiple;
    mont_pkg::acc_t        m_multiple;

    modport regs (
        input  load, shift_a, capture_b3, capture_m3, acc_low, triple,
        output b, m, b_multiple, m_multiple
    );

    modport core (
        output load, shift_a, capture_b3, capture_m3, acc_low, triple,
        input  b, m, b_multiple, m_multiple
    );

endinterface

/* limb_adder.sv */
`timescale 1ns/1ps

module limb_adder (
    input logic    clk,
    input logic    resetn,
    adder_if.adder bus
);

    mont_pkg::acc_t a_in;
    mont_pkg::acc_t b_in;
    mont_pkg::acc_t a_q;
    mont_pkg::acc_t b_q;
    logic [mont_pkg::LIMB_W-1:0] limb_a;
    logic [mont_pkg::LIMB_W-1:0] limb_b;
    logic [mont_pkg::LIMB_W:0] limb_sum;
    logic carry_in;
    logic carry_q;
    // One bit per limb still to add after limb 0
    logic [mont_pkg::NUM_LIMBS-2:0] pending;
    logic busy;

    // Clearing the top operand bit leaves room for the carry in sum
    assign a_in = {1'b0, bus.op_a[mont_pkg::ACC_W-2:0]};
    assign b_in = {1'b0, bus.subtract ? ~bus.op_b[mont_pkg::ACC_W-2:0]
                                      : bus.op_b[mont_pkg::ACC_W-2:0]};

    // Limb 0 straight from the request, the rest from the shifters
    assign limb_a   = bus.start ? a_in[mont_pkg::LIMB_W-1:0] : a_q[mont_pkg::LIMB_W-1:0];
    assign limb_b   = bus.start ? b_in[mont_pkg::LIMB_W-1:0] : b_q[mont_pkg::LIMB_W-1:0];
    assign carry_in = bus.start ? bus.subtract : carry_q;
    assign limb_sum = {1'b0, limb_a} + {1'b0, limb_b}
                    + (mont_pkg::LIMB_W+1)'(carry_in);

    assign busy = |pending;

    always_ff @(posedge clk) begin
        if (bus.start) begin
            a_q <= a_in >> mont_pkg::LIMB_W;
            b_q <= b_in >> mont_pkg::LIMB_W;
        end else if (busy) begin
            a_q <= a_q >> mont_pkg::LIMB_W;
            b_q <= b_q >> mont_pkg::LIMB_W;
        end
        // Limbs enter at the top, limb 0 ends up at the bottom
        if (bus.start || busy) begin
            carry_q <= limb_sum[mont_pkg::LIMB_W];
            bus.sum <= {limb_sum[mont_pkg::LIMB_W-1:0],
                        bus.sum[mont_pkg::ACC_W-1:mont_pkg::LIMB_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending  <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.start) begin
                pending <= '1;
            end else if (busy) begin
                pending <= pending >> 1;
                // Last limb goes in this cycle
                if ((pending >> 1) == '0) begin
                    bus.done <= 1'b1;
                end
            end
        end
    end

endmodule

/* operand_regs.sv */
`timescale 1ns/1ps

module operand_regs (
    input logic          clk,
    input logic          resetn,
    input mont_pkg::op_t in_a,
    input mont_pkg::op_t in_b,
    input mont_pkg::op_t in_m,
    operand_if.regs      ops
);

    mont_pkg::op_t a;
    mont_pkg::op_t b;
    mont_pkg::op_t m;
    logic [mont_pkg::OP_W+1:0] b3;
    logic [mont_pkg::OP_W+1:0] m3;
    logic [1:0] q_digit;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            a  <= '0;
            b  <= '0;
            m  <= '0;
            b3 <= '0;
            m3 <= '0;
        end else begin
            if (ops.load) begin
                a <= in_a;
                b <= in_b;
                m <= in_m;
            end else if (ops.shift_a) begin
                // Next radix-4 digit into a[1:0]
                a <= a >> 2;
            end
            if (ops.capture_b3) begin
                b3 <= ops.triple[mont_pkg::OP_W+1:0];
            end
            if (ops.capture_m3) begin
                m3 <= ops.triple[mont_pkg::OP_W+1:0];
            end
        end
    end

    assign ops.b = b;
    assign ops.m = m;

    // Digit of a picks 0, b, 2b or 3b
    always_comb begin
        case (a[1:0])
            2'd0:    ops.b_multiple = '0;
            2'd1:    ops.b_multiple = mont_pkg::acc_t'(b);
            2'd2:    ops.b_multiple = mont_pkg::acc_t'({b, 1'b0});
            default: ops.b_multiple = mont_pkg::acc_t'(b3);
        endcase
    end

    // q = -c * m^-1 mod 4, and m^-1 mod 4 is m mod 4 for odd m
    assign q_digit = m[1] ? ops.acc_low : 2'd0 - ops.acc_low;

    always_comb begin
        case (q_digit)
            2'd0:    ops.m_multiple = '0;
            2'd1:    ops.m_multiple = mont_pkg::acc_t'(m);
            2'd2:    ops.m_multiple = mont_pkg::acc_t'({m, 1'b0});
            default: ops.m_multiple = mont_pkg::acc_t'(m3);
        endcase
    end

endmodule

/* mont_core.sv */
`timescale 1ns/1ps

module mont_core (
    input  logic           clk,
    input  logic           resetn,
    input  logic           start,
    operand_if.core        ops,
    adder_if               add,
    output logic           handoff,
    output mont_pkg::acc_t acc_out,
    output mont_pkg::op_t  m_out,
    input  logic           reduce_busy
);

    mont_pkg::core_state_t state;
    mont_pkg::core_state_t state_next;
    logic [mont_pkg::DIGIT_CNT_W-1:0] digit_cnt;
    mont_pkg::acc_t c;
    logic last_digit;

    limb_adder i_adder (
        .clk    (clk),
        .resetn (resetn),
        .bus    (add)
    );

    assign last_digit = (digit_cnt == mont_pkg::LAST_DIGIT);

    always_comb begin
        state_next = state;
        case (state)
            mont_pkg::CORE_IDLE: begin
                if (start) begin
                    state_next = mont_pkg::CORE_B3_ISSUE;
                end
            end
            mont_pkg::CORE_B3_ISSUE:   state_next = mont_pkg::CORE_B3_WAIT;
            mont_pkg::CORE_B3_WAIT: begin
                if (add.done) begin
                    state_next = mont_pkg::CORE_M3_ISSUE;
                end
            end
            mont_pkg::CORE_M3_ISSUE:   state_next = mont_pkg::CORE_M3_WAIT;
            mont_pkg::CORE_M3_WAIT: begin
                if (add.done) begin
                    state_next = mont_pkg::CORE_BMUL_ISSUE;
                end
            end
            mont_pkg::CORE_BMUL_ISSUE: state_next = mont_pkg::CORE_BMUL_WAIT;
            mont_pkg::CORE_BMUL_WAIT: begin
                if (add.done) begin
                    state_next = mont_pkg::CORE_MMUL_ISSUE;
                end
            end
            mont_pkg::CORE_MMUL_ISSUE: state_next = mont_pkg::CORE_MMUL_WAIT;
            mont_pkg::CORE_MMUL_WAIT: begin
                if (add.done) begin
                    state_next = last_digit ? mont_pkg::CORE_HANDOFF
                                            : mont_pkg::CORE_BMUL_ISSUE;
                end
            end
            mont_pkg::CORE_HANDOFF: begin
                // Wait here until the output stage is free
                if (!reduce_busy) begin
                    state_next = mont_pkg::CORE_IDLE;
                end
            end
            default:                   state_next = mont_pkg::CORE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= mont_pkg::CORE_IDLE;
            digit_cnt <= '0;
        end else begin
            state <= state_next;
            if (ops.load) begin
                digit_cnt <= '0;
            end else if (ops.shift_a) begin
                digit_cnt <= digit_cnt + 1'b1;
            end
        end
    end

    // Accumulator, kept below 2m through the loop
    always_ff @(posedge clk) begin
        if (ops.load) begin
            c <= '0;
        end else if (state == mont_pkg::CORE_BMUL_WAIT && add.done) begin
            c <= add.sum;
        end else if (ops.shift_a) begin
            // Two low bits are zero after the M pass
            c <= add.sum >> 2;
        end
    end

    // Adder operands, sampled only on add.start
    always_comb begin
        case (state)
            mont_pkg::CORE_B3_ISSUE: begin
                add.op_a = mont_pkg::acc_t'({ops.b, 1'b0});
                add.op_b = mont_pkg::acc_t'(ops.b);
            end
            mont_pkg::CORE_M3_ISSUE: begin
                add.op_a = mont_pkg::acc_t'({ops.m, 1'b0});
                add.op_b = mont_pkg::acc_t'(ops.m);
            end
            mont_pkg::CORE_BMUL_ISSUE: begin
                add.op_a = c;
                add.op_b = ops.b_multiple;
            end
            mont_pkg::CORE_MMUL_ISSUE: begin
                add.op_a = c;
                add.op_b = ops.m_multiple;
            end
            default: begin
                add.op_a = '0;
                add.op_b = '0;
            end
        endcase
    end

    assign add.start = state inside {mont_pkg::CORE_B3_ISSUE, mont_pkg::CORE_M3_ISSUE,
                                     mont_pkg::CORE_BMUL_ISSUE, mont_pkg::CORE_MMUL_ISSUE};
    assign add.subtract = 1'b0;

    assign ops.load       = (state == mont_pkg::CORE_IDLE) && start;
    assign ops.capture_b3 = (state == mont_pkg::CORE_B3_WAIT) && add.done;
    assign ops.capture_m3 = (state == mont_pkg::CORE_M3_WAIT) && add.done;
    assign ops.shift_a    = (state == mont_pkg::CORE_MMUL_WAIT) && add.done;
    assign ops.acc_low    = c[1:0];
    assign ops.triple     = add.sum;

    assign handoff = (state == mont_pkg::CORE_HANDOFF) && !reduce_busy;
    assign acc_out = c;
    assign m_out   = ops.m;

endmodule

/* final_reduce.sv */
`timescale 1ns/1ps

module final_reduce (
    input  logic           clk,
    input  logic           resetn,
    input  logic           handoff,
    input  mont_pkg::acc_t acc_in,
    input  mont_pkg::op_t  m_in,
    output logic           reduce_busy,
    output mont_pkg::op_t  result,
    output logic           done
);

    adder_if sub_bus ();

    mont_pkg::acc_t acc_q;
    mont_pkg::op_t  m_q;
    logic           issue_q;

    limb_adder i_adder (
        .clk    (clk),
        .resetn (resetn),
        .bus    (sub_bus)
    );

    // c - m on the second adder
    assign sub_bus.start    = issue_q;
    assign sub_bus.subtract = 1'b1;
    assign sub_bus.op_a     = acc_q;
    assign sub_bus.op_b     = mont_pkg::acc_t'(m_q);

    always_ff @(posedge clk) begin
        if (handoff) begin
            acc_q <= acc_in;
            m_q   <= m_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            issue_q     <= 1'b0;
            reduce_busy <= 1'b0;
            done        <= 1'b0;
            result      <= '0;
        end else begin
            issue_q <= handoff;
            done    <= sub_bus.done;
            if (handoff) begin
                reduce_busy <= 1'b1;
            end else if (sub_bus.done) begin
                reduce_busy <= 1'b0;
            end
            // Carry set means c >= m, take the difference
            if (sub_bus.done) begin
                result <= sub_bus.sum[mont_pkg::ACC_W-1] ? sub_bus.sum[mont_pkg::OP_W-1:0]
                                                         : acc_q[mont_pkg::OP_W-1:0];
            end
        end
    end

endmodule

/* montgomery_top.sv */
`timescale 1ns/1ps

module montgomery_top (
    input  logic          clk,
    input  logic          resetn,
    input  logic          start,
    input  mont_pkg::op_t in_a,
    input  mont_pkg::op_t in_b,
    input  mont_pkg::op_t in_m,
    output mont_pkg::op_t result,
    output logic          done
);

    operand_if ops_bus ();
    adder_if   core_add ();

    logic           handoff;
    mont_pkg::acc_t acc_out;
    mont_pkg::op_t  m_out;
    logic           reduce_busy;

    operand_regs i_regs (
        .clk    (clk),
        .resetn (resetn),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .ops    (ops_bus)
    );

    mont_core i_core (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .ops         (ops_bus),
        .add         (core_add),
        .handoff     (handoff),
        .acc_out     (acc_out),
        .m_out       (m_out),
        .reduce_busy (reduce_busy)
    );

    // Frees the core for the next operand set
    final_reduce i_reduce (
        .clk         (clk),
        .resetn      (resetn),
        .handoff     (handoff),
        .acc_in      (acc_out),
        .m_in        (m_out),
        .reduce_busy (reduce_busy),
        .result      (result),
        .done        (done)
    );

endmodule

/* montgomery_sva.sv */
`timescale 1ns/1ps

module montgomery_sva (
    input logic clk,
    input logic resetn,
    input logic add_start,
    input logic add_done,
    input logic done_pulse
);

    localparam int CNT_W = $clog2(mont_pkg::NUM_LIMBS);
    localparam logic [CNT_W-1:0] ADD_CYCLES = CNT_W'(mont_pkg::NUM_LIMBS - 1);

    // Cycles left before the add in flight completes
    logic [CNT_W-1:0] remaining;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            remaining <= '0;
        end else if (add_start) begin
            remaining <= ADD_CYCLES;
        end else if (remaining != '0) begin
            remaining <= remaining - CNT_W'(1);
        end
    end

    done_single_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done_pulse |=> !done_pulse)
        else $error("done high for two cycles in a row");

    no_start_while_busy: assert property (@(posedge clk) disable iff (!resetn)
        add_start |-> remaining == '0)
        else $error("adder start while an add is in progress");

    // Adder done lands exactly NUM_LIMBS cycles after its start
    add_latency: assert property (@(posedge clk) disable iff (!resetn)
        add_done |-> $past(remaining) == CNT_W'(1))
        else $error("adder done at the wrong cycle");

    done_low_after_reset: assert property (@(posedge clk)
        !resetn |=> !done_pulse)
        else $error("done high in the cycle after reset");

endmodule

bind mont_core montgomery_sva i_core_sva (
    .clk        (clk),
    .resetn     (resetn),
    .add_start  (add.start),
    .add_done   (add.done),
    .done_pulse (handoff)
);

bind final_reduce montgomery_sva i_reduce_sva (
    .clk        (clk),
    .resetn     (resetn),
    .add_start  (sub_bus.start),
    .add_done   (sub_bus.done),
    .done_pulse (done)
);

/* tb_montgomery.sv */
`timescale 1ns/1ps

module tb_montgomery;

    localparam int unsigned RANDOM_VECTORS = 20;
    localparam int unsigned CHAIN_LENGTH   = 3;
    localparam int unsigned NUM_OPS        = 3 + 2 + RANDOM_VECTORS + CHAIN_LENGTH;
    // Two adder passes per digit, plus setup and reduction slack
    localparam int unsigned OP_BOUND =
        mont_pkg::NUM_DIGITS * 2 * (mont_pkg::NUM_LIMBS + 3) + 50;
    localparam int unsigned TIMEOUT_CYCLES = 2 * NUM_OPS * OP_BOUND + 200;

    logic          clk = 1'b0;
    logic          resetn;
    logic          start;
    mont_pkg::op_t in_a;
    mont_pkg::op_t in_b;
    mont_pkg::op_t in_m;
    mont_pkg::op_t result;
    logic          done;

    logic [31:0] lfsr_state = 32'h36e4;
    int unsigned cycle_count = 0;
    int unsigned test_count = 0;
    int unsigned check_count = 0;
    int unsigned error_count = 0;

    montgomery_top i_dut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no final result after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_operand(output mont_pkg::op_t value);
        int i;
        for (i = 0; i < mont_pkg::OP_W; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value[i] = lfsr_state[0];
        end
    endtask

    // Bit-serial Montgomery product, one bit of a per step
    function automatic mont_pkg::op_t montgomery_reference(input mont_pkg::op_t a,
                                                           input mont_pkg::op_t b,
                                                           input mont_pkg::op_t m);
        logic [mont_pkg::OP_W+1:0] acc;
        int i;
        acc = '0;
        for (i = 0; i < mont_pkg::OP_W; i++) begin
            if (a[i]) begin
                acc = acc + {2'b00, b};
            end
            if (acc[0]) begin
                acc = acc + {2'b00, m};
            end
            acc = acc >> 1;
        end
        if (acc >= {2'b00, m}) begin
            acc = acc - {2'b00, m};
        end
        return acc[mont_pkg::OP_W-1:0];
    endfunction

    task automatic check_value(input string test, input mont_pkg::op_t expected,
                               input mont_pkg::op_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_condition(input string test, input logic ok, input string problem);
        check_count++;
        assert (ok) else begin
            $display("[FAIL] %s: %s", test, problem);
            error_count++;
        end
    endtask

    // Called at a falling edge, returns one falling edge later
    task automatic issue_op(input mont_pkg::op_t a, input mont_pkg::op_t b,
                            input mont_pkg::op_t m);
        in_a  = a;
        in_b  = b;
        in_m  = m;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_done(input string test, input logic check_hold,
                                 input mont_pkg::op_t held, output mont_pkg::op_t value);
        while (done !== 1'b1) begin
            if (check_hold) begin
                check_condition(test, result === held, "result changed before done");
            end
            @(negedge clk);
        end
        value = result;
    endtask

    task automatic run_vector(input string test, input mont_pkg::op_t a,
                              input mont_pkg::op_t b, input mont_pkg::op_t m,
                              output mont_pkg::op_t value);
        issue_op(a, b, m);
        wait_for_done(test, 1'b0, '0, value);
        check_value(test, montgomery_reference(a, b, m), value);
    endtask

    task automatic finish_test(input string test, input int unsigned errors_before);
        test_count++;
        $display("Test %s finished, %0d failed checks", test, error_count - errors_before);
    endtask

    task automatic test_reset_idle();
        int unsigned errors_before;
        int i;
        errors_before = error_count;
        check_value("reset_idle", '0, result);
        for (i = 0; i < 20; i++) begin
            check_condition("reset_idle", done === 1'b0, "done went high without a start");
            @(negedge clk);
        end
        finish_test("reset_idle", errors_before);
    endtask

    task automatic test_small_operands();
        int unsigned errors_before;
        mont_pkg::op_t value;
        errors_before = error_count;
        run_vector("small_operands", mont_pkg::op_t'(1), mont_pkg::op_t'(1),
                   mont_pkg::op_t'(13), value);
        run_vector("small_operands", mont_pkg::op_t'(0), mont_pkg::op_t'(9),
                   mont_pkg::op_t'(13), value);
        check_value("small_operands", '0, value);
        run_vector("small_operands", mont_pkg::op_t'(12), mont_pkg::op_t'(12),
                   mont_pkg::op_t'(13), value);
        finish_test("small_operands", errors_before);
    endtask

    task automatic test_final_subtract();
        int unsigned errors_before;
        mont_pkg::op_t m;
        mont_pkg::op_t m_less;
        mont_pkg::op_t value;
        errors_before = error_count;
        // Just above 2^(N-1), picked so that c ends above m
        m = {1'b1, {(mont_pkg::OP_W-5){1'b0}}, 4'b1001};
        m_less = m - mont_pkg::op_t'(1);
        run_vector("final_subtract", m_less, m_less, m, value);
        run_vector("final_subtract", mont_pkg::op_t'(2), mont_pkg::op_t'(3), m, value);
        finish_test("final_subtract", errors_before);
    endtask

    task automatic random_vector(output mont_pkg::op_t a, output mont_pkg::op_t b,
                                 output mont_pkg::op_t m);
        random_operand(m);
        m[mont_pkg::OP_W-1] = 1'b1;
        m[0] = 1'b1;
        random_operand(a);
        a = a % m;
        random_operand(b);
        b = b % m;
    endtask

    task automatic test_random_vectors();
        int unsigned errors_before;
        mont_pkg::op_t a;
        mont_pkg::op_t b;
        mont_pkg::op_t m;
        mont_pkg::op_t value;
        int i;
        errors_before = error_count;
        for (i = 0; i < RANDOM_VECTORS; i++) begin
            random_vector(a, b, m);
            run_vector("random_vectors", a, b, m, value);
            check_condition("random_vectors", value < m, "result is not below m");
        end
        finish_test("random_vectors", errors_before);
    endtask

    task automatic test_back_to_back();
        int unsigned errors_before;
        mont_pkg::op_t a;
        mont_pkg::op_t b;
        mont_pkg::op_t m;
        mont_pkg::op_t value;
        mont_pkg::op_t held;
        int i;
        errors_before = error_count;
        held = '0;
        for (i = 0; i < CHAIN_LENGTH; i++) begin
            random_vector(a, b, m);
            // Start goes out in the done cycle, sampled one clock later
            issue_op(a, b, m);
            if (i > 0) begin
                check_condition("back_to_back", done === 1'b0, "done lasted more than one cycle");
            end
            wait_for_done("back_to_back", i > 0, held, value);
            held = montgomery_reference(a, b, m);
            check_value("back_to_back", held, value);
        end
        @(negedge clk);
        check_condition("back_to_back", done === 1'b0, "done lasted more than one cycle");
        check_value("back_to_back", held, result);
        finish_test("back_to_back", errors_before);
    endtask

    initial begin
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        test_reset_idle();
        test_small_operands();
        test_final_subtract();
        test_random_vectors();
        test_back_to_back();
        $display("Summary: %0d tests, %0d checks, %0d failed", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
mont_pkg.sv
adder_if.sv
operand_if.sv
limb_adder.sv
operand_regs.sv
mont_core.sv
final_reduce.sv
montgomery_top.sv
montgomery_sva.sv
tb_montgomery.sv

/* run.sh */
#!/bin/sh
# Build and run the Montgomery multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_montgomery \
    -f verilog.f --Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation passed"
exit 0
